//--- sources.f
video_pkg.sv
word_unpacker.sv
pixel_ring.sv
raster_gen.sv
stream_to_video.sv
tb_stream_to_video.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the stream_to_video testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f sources.f \
    --top-module tb_stream_to_video --Mdir obj_dir -o sim_tb
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
run_status=$?
cat sim.log
if [ $run_status -ne 0 ]; then
    echo "simulation exited with status $run_status"
    exit 1
fi

grep -q "Simulation completed successfully" sim.log
if [ $? -ne 0 ]; then
    echo "pass message not found in sim.log"
    exit 1
fi

echo "run passed"
exit 0

//--- tb_stream_to_video.sv
// testbench: clock and reset, random word source, reference queue, output comparator, timeout
`timescale 1ns/1ns

module tb_stream_to_video;

    // small raster so a frame is only 252 cycles
    localparam int H_TOT = 28;
    localparam int H_SY  = 4;
    localparam int H_DI  = 16;
    localparam int V_SY  = 2;
    localparam int V_DI  = 4;
    localparam int FRAME = 252;
    // reset, start delay and about 12 frames, with margin
    localparam int MAX_CYCLES = 4000;
    localparam logic [7:0] PRE_TAG = 8'hDE;  // top byte of pixels sent before arming

    logic                  pixel_clk = 1'b0;
    logic                  rst_n;
    logic                  word_valid;
    video_pkg::word_t      word_data;
    logic                  word_ready;
    video_pkg::video_out_t video;

    video_pkg::rgb_t exp_pix[$];   // expected pixels in display order
    int              exp_due[$];   // first check cycle each pixel can be shown
    int  cyc = 0;
    int  hs_low = 0;               // consecutive cycles with hs low
    int  vs_rises = 0;
    int  rises_since_bnd = 0;
    int  full_frames = 0;          // frames whose shape was checked
    int  shown = 0;
    int  first_bnd_cyc = -1;
    int  pixel_rate = 0;           // words offered per 8 cycles
    logic taken = 1'b0;            // word on the bus goes at the next edge
    logic send_bnd = 1'b0;
    logic bnd_on = 1'b0;           // boundary at each vs fall
    logic sent_bnd = 1'b0;
    logic saw_stall = 1'b0;

    stream_to_video #(
        .H_SYNC (4), .H_BACK (4), .H_DISP (16), .H_FRONT (4),
        .V_SYNC (2), .V_BACK (2), .V_DISP (4),  .V_FRONT (1)
    ) uut (
        .pixel_clk  (pixel_clk),
        .rst_n      (rst_n),
        .word_valid (word_valid),
        .word_data  (word_data),
        .word_ready (word_ready),
        .video      (video)
    );

    always #20 pixel_clk = ~pixel_clk;

    task automatic report_value(input string name, input int exp_v, input int got_v);
        $display("[ERROR] %0t ns: %s expected %0h, got %0h", $time, name, exp_v, got_v);
        $display("Simulation failed");
        $fatal(1);
    endtask

    task automatic report_problem(input string what);
        $display("[ERROR] %0t ns: %s", $time, what);
        $display("Simulation failed");
        $fatal(1);
    endtask

    // ======================================================================
    // reference model and word generation
    // ======================================================================
    // pixels carried by a word, 3 marks a boundary
    function automatic int decode_word(input video_pkg::word_t w,
                                       output video_pkg::rgb_t p0,
                                       output video_pkg::rgb_t p1);
        logic [1:0] k;
        k  = w[15:14];
        p0 = w[39:16];
        p1 = w[63:40];
        if (k == 2'b11)
            return (w[63:16] == {6{8'hFE}}) ? 3 : 0;  // bad pattern is ignored
        return int'(k);
    endfunction

    function automatic video_pkg::rgb_t random_pixel(input logic pre_arm);
        video_pkg::rgb_t p;
        p = 24'($urandom);
        p[23:16] = pre_arm ? PRE_TAG : (p[23:16] & 8'h7F);
        p[0] = 1'b1;  // never black, black means underrun
        return p;
    endfunction

    function automatic video_pkg::word_t pixel_word(input logic pre_arm);
        logic [1:0] k;
        k = 2'($urandom % 3);  // none, one or two
        return {random_pixel(pre_arm), random_pixel(pre_arm), k, 14'($urandom)};
    endfunction

    // source, holds each word until it transfers
    initial begin : source
        void'($urandom(35));
        forever begin
            @(posedge pixel_clk);
            #2;
            if (rst_n && (!word_valid || taken)) begin
                if (send_bnd) begin
                    word_data  = {48'hFEFE_FEFE_FEFE, 2'b11, 14'($urandom)};
                    word_valid = 1'b1;
                    send_bnd   = 1'b0;
                    sent_bnd   = 1'b1;
                end else if (pixel_rate > 0 && int'($urandom % 8) < pixel_rate) begin
                    word_data  = pixel_word(!sent_bnd);
                    word_valid = 1'b1;
                end else begin
                    word_valid = 1'b0;
                end
            end
        end
    end

    // ======================================================================
    // monitor and comparator, sampled at the falling edge
    // ======================================================================
    always @(negedge pixel_clk) begin : monitor
        int                    n;
        video_pkg::rgb_t       p0;
        video_pkg::rgb_t       p1;
        logic                  hs_fall;
        logic                  hs_rise;
        logic                  vs_fall;
        logic                  vs_rise;
        logic                  de_rise;
        logic                  de_fall;
        static video_pkg::video_out_t prev = '0;
        static logic model_armed = 1'b0;
        static int last_hs_fall = -1;
        static int last_vs_fall = -1;
        static int last_vs_rise = -1;
        static int de_rise_cyc = 0;
        static int de_lines = 0;

        cyc = cyc + 1;
        if (cyc >= MAX_CYCLES)
            report_problem("timeout, the run did not finish in time");

        // word handshake that completes at the next rising edge
        taken = word_valid && word_ready;
        if (word_valid && !word_ready)
            saw_stall = 1'b1;
        if (taken) begin
            n = decode_word(word_data, p0, p1);
            if (n == 3) begin
                model_armed     = 1'b1;
                rises_since_bnd = 0;
                if (first_bnd_cyc < 0)
                    first_bnd_cyc = cyc;
            end else if (model_armed) begin
                if (n >= 1) begin
                    exp_pix.push_back(p0);
                    exp_due.push_back(cyc + 3);  // ring write, pop, output register
                end
                if (n == 2) begin
                    exp_pix.push_back(p1);
                    exp_due.push_back(cyc + 3);
                end
            end
        end

        // quiet until the start delay has run out and the first h sync ends
        // boundary pulse 1, delay 16, output register 1, then H_SY sync columns
        if (first_bnd_cyc < 0 || cyc < first_bnd_cyc + 18 + H_SY)
            assert (video == '0) else report_problem("video active before the raster start");
        else if (cyc == first_bnd_cyc + 18 + H_SY)
            assert (video.hs) else report_value("video.hs", 1, int'(video.hs));

        // pixel stream
        if (video.de) begin
            assert (video.hs && video.vs) else report_problem("de high during sync");
            if (video.rgb != '0) begin
                assert (video.rgb[23:16] != PRE_TAG)
                    else report_problem("pixel from before the first boundary shown");
                assert (exp_pix.size() > 0 && exp_due[0] <= cyc)
                    else report_problem("pixel shown that was never stored");
                assert (video.rgb == exp_pix[0])
                    else report_value("video.rgb", int'(exp_pix[0]), int'(video.rgb));
                void'(exp_pix.pop_front());
                void'(exp_due.pop_front());
                shown = shown + 1;
            end else begin
                // black allowed only on underrun
                assert (exp_due.size() == 0 || exp_due[0] > cyc)
                    else report_value("video.rgb", int'(exp_pix[0]), 0);
            end
        end else begin
            assert (video.rgb == '0) else report_value("video.rgb", 0, int'(video.rgb));
        end

        hs_fall = prev.hs && !video.hs;
        hs_rise = !prev.hs && video.hs;
        vs_fall = prev.vs && !video.vs;
        vs_rise = !prev.vs && video.vs;
        de_rise = !prev.de && video.de;
        de_fall = prev.de && !video.de;

        hs_low = video.hs ? 0 : hs_low + 1;
        if (hs_low > H_TOT) begin  // raster stopped, restart tracking
            last_hs_fall = -1;
            last_vs_fall = -1;
            last_vs_rise = -1;
        end

        // line shape
        if (hs_fall) begin
            if (last_hs_fall >= 0)
                assert (cyc - last_hs_fall == H_TOT)
                    else report_value("line length", H_TOT, cyc - last_hs_fall);
            last_hs_fall = cyc;
        end
        if (hs_rise && last_hs_fall >= 0)
            assert (cyc - last_hs_fall == H_SY)
                else report_value("video.hs low time", H_SY, cyc - last_hs_fall);

        // frame shape
        if (vs_fall) begin
            last_vs_fall = cyc;
            if (bnd_on)
                send_bnd = 1'b1;  // one boundary per frame
        end
        if (vs_rise) begin
            vs_rises        = vs_rises + 1;
            rises_since_bnd = rises_since_bnd + 1;
            if (last_vs_fall >= 0)
                assert (cyc - last_vs_fall == V_SY * H_TOT)
                    else report_value("video.vs low time", V_SY * H_TOT, cyc - last_vs_fall);
            if (last_vs_rise >= 0) begin
                assert (cyc - last_vs_rise == FRAME)
                    else report_value("frame length", FRAME, cyc - last_vs_rise);
                assert (de_lines == V_DI) else report_value("active lines", V_DI, de_lines);
                full_frames = full_frames + 1;
            end
            last_vs_rise = cyc;
            de_lines     = 0;
        end

        // active window, and the watchdog stop
        if (de_rise) begin
            assert (rises_since_bnd < 4)
                else report_problem("de rose after the boundary watchdog limit");
            de_rise_cyc = cyc;
            de_lines    = de_lines + 1;
        end
        if (de_fall)
            assert (cyc - de_rise_cyc == H_DI)
                else report_value("video.de run length", H_DI, cyc - de_rise_cyc);

        prev = video;
    end

    // ======================================================================
    // test sequence
    // ======================================================================
    initial begin : main
        int restart_rises;
        int frames_before;
        rst_n      = 1'b0;
        word_valid = 1'b0;
        word_data  = '0;
        repeat (10) @(posedge pixel_clk);
        #2 rst_n = 1'b1;
        @(negedge pixel_clk);
        assert (word_ready) else report_problem("word_ready low after reset");

        pixel_rate = 8;  // words that must be dropped, not armed yet
        repeat (30) @(posedge pixel_clk);
        send_bnd = 1'b1;
        bnd_on   = 1'b1;
        wait (vs_rises >= 5);

        // boundaries stop, ring drains, watchdog should halt the raster
        bnd_on     = 1'b0;
        pixel_rate = 0;
        wait (hs_low > H_TOT);
        repeat (FRAME) @(posedge pixel_clk);

        restart_rises = vs_rises;
        frames_before = full_frames;
        send_bnd   = 1'b1;
        bnd_on     = 1'b1;
        pixel_rate = 8;
        wait (vs_rises >= restart_rises + 4);

        assert (saw_stall) else report_problem("word_ready never fell under a full ring");
        assert (shown > 100) else report_problem("too few pixels were shown");
        assert (full_frames - frames_before >= 3)
            else report_problem("raster did not resume after the new boundary");
        $display("Simulation completed successfully");
        $finish;
    end

endmodule

//--- stream_to_video.sv
// top level: stream unpacker, pixel ring and raster generator
`timescale 1ns/1ns

module stream_to_video #(
    parameter int H_SYNC  = video_pkg::H_SYNC_DEF,
    parameter int H_BACK  = video_pkg::H_BACK_DEF,
    parameter int H_DISP  = video_pkg::H_DISP_DEF,
    parameter int H_FRONT = video_pkg::H_FRONT_DEF,
    parameter int V_SYNC  = video_pkg::V_SYNC_DEF,
    parameter int V_BACK  = video_pkg::V_BACK_DEF,
    parameter int V_DISP  = video_pkg::V_DISP_DEF,
    parameter int V_FRONT = video_pkg::V_FRONT_DEF
) (
    input  logic                  pixel_clk,
    input  logic                  rst_n,
    input  logic                  word_valid,
    input  video_pkg::word_t      word_data,
    output logic                  word_ready,
    output video_pkg::video_out_t video
);

    video_pkg::pixel_push_t push;          // unpacker to ring
    logic                   ring_room;     // ring back-pressure
    logic                   boundary_seen; // starts and feeds the raster
    logic                   pop;
    video_pkg::rgb_t        head;
    logic                   empty;

    // ======================================================================
    // producer, buffer, consumer
    // ======================================================================
    word_unpacker u_unpacker (
        .pixel_clk     (pixel_clk),
        .rst_n         (rst_n),
        .word_valid    (word_valid),
        .word_data     (word_data),
        .word_ready    (word_ready),
        .ring_room     (ring_room),
        .push          (push),
        .boundary_seen (boundary_seen)
    );

    pixel_ring u_ring (
        .pixel_clk (pixel_clk),
        .rst_n     (rst_n),
        .push      (push),
        .room      (ring_room),
        .pop       (pop),
        .head      (head),
        .empty     (empty)
    );

    raster_gen #(
        .H_SYNC  (H_SYNC),
        .H_BACK  (H_BACK),
        .H_DISP  (H_DISP),
        .H_FRONT (H_FRONT),
        .V_SYNC  (V_SYNC),
        .V_BACK  (V_BACK),
        .V_DISP  (V_DISP),
        .V_FRONT (V_FRONT)
    ) u_raster (
        .pixel_clk     (pixel_clk),
        .rst_n         (rst_n),
        .boundary_seen (boundary_seen),
        .empty         (empty),
        .head          (head),
        .pop           (pop),
        .video         (video)
    );

endmodule

//--- raster_gen.sv
// raster generator: start delay FSM, h/v counters, sync/de timing, pixel pop, watchdog
`timescale 1ns/1ns

module raster_gen #(
    parameter int H_SYNC  = video_pkg::H_SYNC_DEF,
    parameter int H_BACK  = video_pkg::H_BACK_DEF,
    parameter int H_DISP  = video_pkg::H_DISP_DEF,
    parameter int H_FRONT = video_pkg::H_FRONT_DEF,
    parameter int V_SYNC  = video_pkg::V_SYNC_DEF,
    parameter int V_BACK  = video_pkg::V_BACK_DEF,
    parameter int V_DISP  = video_pkg::V_DISP_DEF,
    parameter int V_FRONT = video_pkg::V_FRONT_DEF
) (
    input  logic                  pixel_clk,
    input  logic                  rst_n,
    input  logic                  boundary_seen,
    input  logic                  empty,
    input  video_pkg::rgb_t       head,
    output logic                  pop,
    output video_pkg::video_out_t video
);

    // frame geometry derived from the porch values
    localparam int H_TOTAL   = H_SYNC + H_BACK + H_DISP + H_FRONT;
    localparam int V_TOTAL   = V_SYNC + V_BACK + V_DISP + V_FRONT;
    localparam int H_ACT_BEG = H_SYNC + H_BACK;
    localparam int H_ACT_END = H_ACT_BEG + H_DISP;
    localparam int V_ACT_BEG = V_SYNC + V_BACK;
    localparam int V_ACT_END = V_ACT_BEG + V_DISP;

    video_pkg::raster_state_t state;
    video_pkg::count_t        cnt_h;
    video_pkg::count_t        cnt_v;
    video_pkg::count_t        delay_cnt;  // counts down during R_DELAY
    logic [1:0]               miss_cnt;   // frames with no boundary
    logic                     seen_q;     // boundary since last vs rise
    logic                     run;
    logic                     hs_c;
    logic                     vs_c;
    logic                     en_c;       // active window from counters
    logic                     vs_rise;    // vs goes high on next output
    logic                     timeout;

    // ======================================================================
    // counter decode
    // ======================================================================
    assign run  = (state == video_pkg::R_RUN);
    assign hs_c = (cnt_h >= H_SYNC);     // low during h sync
    assign vs_c = (cnt_v >= V_SYNC);     // low during v sync
    assign en_c = (cnt_h >= H_ACT_BEG) && (cnt_h < H_ACT_END) &&
                  (cnt_v >= V_ACT_BEG) && (cnt_v < V_ACT_END);

    assign pop = run && en_c && !empty;  // underrun shows black, no pop

    assign vs_rise = run && vs_c && !video.vs;
    // third boundary-free vs rise in a row stops the raster
    assign timeout = vs_rise && !seen_q && !boundary_seen &&
                     (int'(miss_cnt) == video_pkg::MISS_LIMIT - 1);

    // ======================================================================
    // state machine and counters
    // ======================================================================
    always_ff @(posedge pixel_clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= video_pkg::R_IDLE;
            delay_cnt <= '0;
            cnt_h     <= '0;
            cnt_v     <= '0;
        end else begin
            case (state)
                video_pkg::R_IDLE: begin
                    cnt_h <= '0;
                    cnt_v <= '0;
                    if (boundary_seen) begin
                        state     <= video_pkg::R_DELAY;
                        delay_cnt <= video_pkg::count_t'(video_pkg::BOUNDARY_DELAY - 1);
                    end
                end
                video_pkg::R_DELAY: begin
                    if (delay_cnt == video_pkg::count_t'(1))
                        state <= video_pkg::R_RUN; // run starts at counter 0
                    else
                        delay_cnt <= delay_cnt - video_pkg::count_t'(1);
                end
                video_pkg::R_RUN: begin
                    if (timeout) begin
                        state <= video_pkg::R_IDLE;
                        cnt_h <= '0;
                        cnt_v <= '0;
                    end else if (int'(cnt_h) == H_TOTAL - 1) begin
                        cnt_h <= '0;
                        if (int'(cnt_v) == V_TOTAL - 1)
                            cnt_v <= '0;  // frame wrap
                        else
                            cnt_v <= cnt_v + video_pkg::count_t'(1);
                    end else begin
                        cnt_h <= cnt_h + video_pkg::count_t'(1);
                    end
                end
                default: state <= video_pkg::R_IDLE;
            endcase
        end
    end

    // boundary watchdog, sampled at each vs rise
    always_ff @(posedge pixel_clk or negedge rst_n) begin
        if (!rst_n) begin
            seen_q   <= 1'b0;
            miss_cnt <= 2'd0;
        end else if (timeout) begin
            seen_q   <= 1'b0;
            miss_cnt <= 2'd0;
        end else if (vs_rise) begin
            seen_q   <= 1'b0;
            // a boundary on this same cycle still counts for the frame
            miss_cnt <= (seen_q || boundary_seen) ? 2'd0 : miss_cnt + 2'd1;
        end else if (boundary_seen) begin
            seen_q <= 1'b1;
        end
    end

    // registered outputs, one cycle behind the counters
    always_ff @(posedge pixel_clk or negedge rst_n) begin
        if (!rst_n) begin
            video <= '0;
        end else begin
            video.hs  <= run && hs_c;
            video.vs  <= run && vs_c;
            video.de  <= run && en_c;            // high even on underrun
            video.rgb <= pop ? head : '0;        // popped pixel, same cycle as de
        end
    end

endmodule

//--- pixel_ring.sv
// pixel ring buffer: 128 entries, one-or-two pixel write, single pop, occupancy
`timescale 1ns/1ns

module pixel_ring (
    input  logic                   pixel_clk,
    input  logic                   rst_n,
    input  video_pkg::pixel_push_t push,
    output logic                   room,
    input  logic                   pop,
    output video_pkg::rgb_t        head,
    output logic                   empty
);

    localparam int LEVEL_W = $clog2(video_pkg::RING_DEPTH) + 1; // holds 0..depth

    video_pkg::rgb_t        mem [video_pkg::RING_DEPTH];
    video_pkg::ring_addr_t  wr_ptr;
    video_pkg::ring_addr_t  rd_ptr;
    video_pkg::ring_addr_t  wr_ptr_nx;  // slot for the second pixel
    logic [LEVEL_W-1:0]     level;      // entries in use
    logic                   pop_ok;

    assign wr_ptr_nx = wr_ptr + video_pkg::ring_addr_t'(1); // wraps at 128
    assign pop_ok    = pop && !empty;

    assign empty = (level == '0);
    assign head  = mem[rd_ptr];    // combinational head for the raster

    // pending push counts as used, so a word accepted now always fits
    assign room = (int'(level) + int'(push.count)) <= (video_pkg::RING_DEPTH - 2);

    // ======================================================================
    // storage
    // ======================================================================
    always_ff @(posedge pixel_clk) begin
        if (push.count != 2'd0)
            mem[wr_ptr] <= push.first;
        if (push.count == 2'd2)
            mem[wr_ptr_nx] <= push.second; // second pixel right behind first
    end

    // pointers and occupancy
    always_ff @(posedge pixel_clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            level  <= '0;
        end else begin
            wr_ptr <= wr_ptr + video_pkg::ring_addr_t'(push.count);
            if (pop_ok)
                rd_ptr <= rd_ptr + video_pkg::ring_addr_t'(1);
            level <= level + LEVEL_W'(push.count) - LEVEL_W'(pop_ok);
        end
    end

endmodule

//--- word_unpacker.sv
// stream word decoder: boundary detect, arming, one/two pixel push into the ring
`timescale 1ns/1ns

module word_unpacker (
    input  logic                   pixel_clk,
    input  logic                   rst_n,
    input  logic                   word_valid,
    input  video_pkg::word_t       word_data,
    output logic                   word_ready,
    input  logic                   ring_room,
    output video_pkg::pixel_push_t push,
    output logic                   boundary_seen
);

    video_pkg::word_kind_t kind;
    logic                  xfer;       // word handshake this cycle
    logic                  is_bnd;     // flag and pattern both match
    logic [1:0]            n_pix;      // pixels carried by this word
    logic                  armed;      // set by first boundary, stays set
    logic [1:0]            count_q;
    video_pkg::rgb_t       first_q;
    video_pkg::rgb_t       second_q;

    // back-pressure straight from the ring, boundaries obey it too
    assign word_ready = ring_room;
    assign xfer       = word_valid && word_ready;

    // ======================================================================
    // decode
    // ======================================================================
    always_comb begin
        kind   = video_pkg::word_kind_t'(word_data[15:14]);
        is_bnd = (kind == video_pkg::KIND_BOUNDARY) &&
                 (word_data[63:16] == video_pkg::BOUNDARY_PATTERN);
        case (kind)
            video_pkg::KIND_NONE:     n_pix = 2'd0;
            video_pkg::KIND_ONE:      n_pix = 2'd1;
            video_pkg::KIND_TWO:      n_pix = 2'd2;
            video_pkg::KIND_BOUNDARY: n_pix = 2'd0; // marker, no pixel data
        endcase
    end

    // control: arm flag, boundary pulse, push count
    always_ff @(posedge pixel_clk or negedge rst_n) begin
        if (!rst_n) begin
            armed         <= 1'b0;
            boundary_seen <= 1'b0;
            count_q       <= 2'd0;
        end else begin
            boundary_seen <= xfer && is_bnd; // one cycle after the transfer
            // pixels before arming are accepted but dropped here
            count_q       <= (xfer && armed && !is_bnd) ? n_pix : 2'd0;
            if (xfer && is_bnd)
                armed <= 1'b1;
        end
    end

    // pixel payload, only meaningful while count_q is nonzero
    always_ff @(posedge pixel_clk) begin
        if (xfer) begin
            first_q  <= word_data[39:16];
            second_q <= word_data[63:40];
        end
    end

    assign push = '{first: first_q, second: second_q, count: count_q};

endmodule

//--- video_pkg.sv
// package: stream word format, raster defaults, ring sizing, vector types, bus structs
package video_pkg;

    // ======================================================================
    // stream word format
    // ======================================================================
    typedef logic [63:0] word_t;    // one stream word
    typedef logic [23:0] rgb_t;     // rgb888 pixel
    typedef logic [1:0]  word_kind_t; // kind flag, word bits 15:14

    localparam word_kind_t KIND_NONE     = 2'b00; // ignored word
    localparam word_kind_t KIND_ONE      = 2'b01; // pixel in 39:16
    localparam word_kind_t KIND_TWO      = 2'b10; // pixels in 39:16 then 63:40
    localparam word_kind_t KIND_BOUNDARY = 2'b11; // frame boundary marker

    // bits 63:16 of a real boundary word
    localparam logic [47:0] BOUNDARY_PATTERN = 48'hFEFE_FEFE_FEFE;

    // ======================================================================
    // raster defaults, 1080p60 timing
    // ======================================================================
    typedef logic [11:0] count_t;   // h/v counter width

    localparam int H_SYNC_DEF  = 44;
    localparam int H_BACK_DEF  = 148;
    localparam int H_DISP_DEF  = 1920;
    localparam int H_FRONT_DEF = 88;

    localparam int V_SYNC_DEF  = 5;
    localparam int V_BACK_DEF  = 36;
    localparam int V_DISP_DEF  = 1080;
    localparam int V_FRONT_DEF = 4;

    localparam int BOUNDARY_DELAY = 16; // boundary pulse to raster start
    localparam int MISS_LIMIT     = 3;  // frames without boundary before stop

    // ======================================================================
    // ring buffer and bus structs
    // ======================================================================
    localparam int RING_DEPTH = 128;
    typedef logic [6:0] ring_addr_t; // wraps at RING_DEPTH

    // one ring write, up to two pixels in order
    typedef struct packed {
        rgb_t       first;
        rgb_t       second;
        logic [1:0] count;  // 0, 1 or 2 pixels valid
    } pixel_push_t;

    // raster output bundle
    typedef struct packed {
        logic hs;
        logic vs;
        logic de;
        rgb_t rgb;
    } video_out_t;

    typedef enum logic [1:0] {
        R_IDLE,   // waiting for a boundary
        R_DELAY,  // start delay running
        R_RUN     // raster active
    } raster_state_t;

endpackage
